/* tb.f */
+incdir+verilog
verilog/lisp_pkg.sv
verilog/core_ifs.sv
verilog/fetch_unit.sv
verilog/stack_datapath.sv
verilog/control_fsm.sv
verilog/lisp_core.sv
tb/tb_clock.sv
tb/tb_lisp_core.sv

/* tb/tb_lisp_core.sv */
`timescale 1ns/1ps
`include "lisp_consts.svh"

module tb_lisp_core;
	import lisp_pkg::*;

	localparam int MEM_WORDS = `LISP_MEM_SIZE;

	logic  clk;
	logic  rst;
	addr_t memory_address;
	word_t mem_read_value;
	word_t mem_write_value;
	logic  mem_write_enable;

	word_t mem [0:MEM_WORDS-1];
	word_t ref_mem [0:MEM_WORDS-1];
	word_t rd_q;
	addr_t s_addr;
	logic  s_we;
	word_t s_wdata;
	logic  s_rst;
	addr_t exp_addr[$];
	word_t exp_val[$];
	int    exp_idx;
	int    pword;
	int    pslot;
	int    end_word;
	int    steps;
	int    seed;
	bit    ref_ready;

	tb_clock #(.PERIOD(4.0)) clk0 (.clk(clk));

	lisp_core dut0 (
		.clk              (clk),
		.rst              (rst),
		.memory_address   (memory_address),
		.mem_read_value   (mem_read_value),
		.mem_write_value  (mem_write_value),
		.mem_write_enable (mem_write_enable)
	);

	task automatic report_failure();
		$display("Checks failed");
		$fatal(1, "Stopping at the first error");
	endtask

	function automatic bit param_fits(input int p, input int w);
		if (w == 0)
			return p == 0;
		return (p >= -(1 << (w - 1))) && (p < (1 << (w - 1)));
	endfunction

	task automatic advance_word();
		pword++;
		pslot = 0;
		mem[pword] = '0;
	endtask

	task automatic new_word();
		if (pslot != 0)
			advance_word();
	endtask

	task automatic org(input int target);
		new_word();
		while (pword < target)
			advance_word();
	endtask

	// Pack one opcode into the current slot with its parameter in the bits below it
	task automatic emit(input logic [4:0] op, input int p);
		int w;
		w = 15 - 5 * pslot;
		if (op[4:3] == 2'b11 && !param_fits(p, w))
		begin
			advance_word();
			w = 15;
		end
		mem[pword] = mem[pword] | (word_t'(op) << w) | (word_t'(p) & ((word_t'(1) << w) - 1));
		if (op[4:3] == 2'b11 || pslot == 3)
			advance_word();
		else
			pslot++;
	endtask

	task automatic emit_branch(input logic [4:0] op, input int target);
		if (!param_fits(target - pword, 15 - 5 * pslot))
			advance_word();
		emit(op, target - pword);
	endtask

	task automatic build_program();
		int a;
		int b;
		int k;
		opcode_e arith[6];
		opcode_e logic_ops[5];
		arith = '{op_add, op_sub, op_gtr, op_gte, op_eq, op_neq};
		logic_ops = '{op_and, op_or, op_xor, op_lshift, op_rshift};
		pword = 0;
		pslot = 0;
		mem[0] = '0;
		// Spills the reset TOS just below the initial SP
		emit(op_push, 5);
		for (k = 0; k < 6; k++)
		begin
			a = $random(seed) & 'hff;
			// Equal operands for gte and eq
			b = (k == 3 || k == 4) ? a : ($random(seed) & 'hff);
			emit(op_push, a);
			emit(op_push, b);
			emit(arith[k], 0);
			emit(op_push, 4096 + k);
			emit(op_store, 0);
		end
		// Tagged TOS comes from a preloaded word
		for (k = 0; k < 5; k++)
		begin
			if (k >= 3)
				a = $random(seed) & 15;
			else
				a = $random(seed) & 'h3fff;
			emit(op_push, a);
			emit(op_push, 4000 + k);
			emit(op_load, 0);
			emit(logic_ops[k], 0);
			emit(op_push, 4110 + k);
			emit(op_store, 0);
		end
		emit(op_push, 4020);
		emit(op_load, 0);
		emit(op_dup, 0);
		emit(op_push, 4100);
		emit(op_store, 0);
		emit(op_pop, 0);
		emit(op_push, 4021);
		emit(op_load, 0);
		emit(op_push, 4101);
		emit(op_store, 0);
		emit_branch(op_goto, 310);
		// Reached only by the backward bfalse
		org(300);
		emit(op_push, 66);
		emit_branch(op_goto, 320);
		org(310);
		emit(op_push, 0);
		emit_branch(op_bfalse, 300);
		emit(op_push, 99);
		org(320);
		emit(op_push, 4);
		emit_branch(op_bfalse, 340);
		emit(op_push, 33);
		emit(op_push, 0);
		emit_branch(op_bfalse, 330);
		emit(op_push, 88);
		org(330);
		emit(op_push, 44);
		emit_branch(op_goto, 340);
		// Parameter in slot 1, then a word with all four slots used
		org(340);
		emit(op_dup, 0);
		emit(op_push, 7);
		emit(op_dup, 0);
		emit(op_pop, 0);
		emit(op_dup, 0);
		emit(op_add, 0);
		emit(op_push, 4200);
		emit(op_store, 0);
		new_word();
		end_word = pword;
		emit_branch(op_goto, end_word);
	endtask

	function automatic void record_write(input int a, input word_t v);
		exp_addr.push_back(addr_t'(a));
		exp_val.push_back(v);
		ref_mem[a % MEM_WORDS] = v;
	endfunction

	function automatic addr_t alu_ref(input logic [4:0] op, input addr_t a, input addr_t b);
		case (op)
			op_add:    return a + b;
			op_sub:    return a - b;
			op_gtr:    return (a > b) ? 16'd1 : 16'd0;
			op_gte:    return (a >= b) ? 16'd1 : 16'd0;
			op_eq:     return (a == b) ? 16'd1 : 16'd0;
			op_neq:    return (a != b) ? 16'd1 : 16'd0;
			op_and:    return a & b;
			op_or:     return a | b;
			op_xor:    return a ^ b;
			op_lshift: return a << b;
			default:   return a >> b;
		endcase
	endfunction

	// Interprets the program and returns the number of executed instructions
	function automatic int run_reference();
		int word_idx;
		int slot;
		int n;
		int p;
		int width;
		int sp;
		logic [4:0] op;
		word_t w;
		word_t tos;
		bit done;
		for (int i = 0; i < MEM_WORDS; i++)
			ref_mem[i] = mem[i];
		word_idx = 0;
		slot = 0;
		n = 0;
		sp = `LISP_SP_RESET;
		tos = '0;
		done = 0;
		while (!done && n < 10000)
		begin
			w = ref_mem[word_idx];
			width = 15 - 5 * slot;
			op = 5'((w >> width) & 20'h1f);
			p = (width == 0) ? 0 : (int'(w) & ((1 << width) - 1));
			if (width > 0 && p >= (1 << (width - 1)))
				p = p - (1 << width);
			n++;
			// Default next position
			if (op[4:3] == 2'b11 || slot == 3)
			begin
				word_idx++;
				slot = 0;
			end
			else
				slot++;
			case (op)
				op_push, op_dup:
				begin
					record_write(sp - 1, tos);
					sp--;
					if (op == op_push)
						tos = word_t'(p);
				end
				op_pop:
				begin
					tos = ref_mem[sp];
					sp++;
				end
				op_load:
					tos = ref_mem[tos[12:0]];
				op_store:
				begin
					record_write(tos[15:0], ref_mem[sp]);
					sp++;
					tos = ref_mem[sp];
					sp++;
				end
				op_goto:
				begin
					if (p == 0)
						done = 1;
					word_idx = word_idx - 1 + p;
				end
				op_bfalse:
				begin
					if (tos[15:0] == '0)
						word_idx = word_idx - 1 + p;
					tos = ref_mem[sp];
					sp++;
				end
				op_add, op_sub, op_gtr, op_gte, op_eq, op_neq,
				op_and, op_or, op_xor, op_lshift, op_rshift:
				begin
					tos[15:0] = alu_ref(op, tos[15:0], ref_mem[sp][15:0]);
					sp++;
				end
				default:
					;
			endcase
		end
		return n;
	endfunction

	// Read data follows the address of the previous cycle
	always @(negedge clk)
	begin
		mem_read_value = rd_q;
		#1;
		s_addr = memory_address;
		s_we = mem_write_enable;
		s_wdata = mem_write_value;
		s_rst = rst;
	end

	always @(posedge clk)
	begin
		rd_q = mem[s_addr[12:0]];
		if (s_we && !s_rst)
			mem[s_addr[12:0]] = s_wdata;
	end

	// Write checker
	always @(posedge clk)
	begin
		if (s_rst)
		begin
			assert (!s_we)
			else
			begin
				$display("Memory write enable was high while reset was asserted");
				report_failure();
			end
		end
		else if (s_we)
		begin
			assert (exp_idx < exp_addr.size())
			else
			begin
				$display("Memory write seen after all expected writes were done");
				report_failure();
			end
			assert (s_addr == exp_addr[exp_idx])
			else
			begin
				$display("[ERROR] %0t memory_address: expected %h, got %h",
					$time, exp_addr[exp_idx], s_addr);
				report_failure();
			end
			assert (s_wdata == exp_val[exp_idx])
			else
			begin
				$display("[ERROR] %0t mem_write_value: expected %h, got %h",
					$time, exp_val[exp_idx], s_wdata);
				report_failure();
			end
			exp_idx++;
		end
	end

	initial
	begin
		wait (ref_ready);
		repeat ((steps * 4 + 10) * 2) @(posedge clk);
		$display("Timeout: the program did not reach its final loop in time");
		$display("Checks failed");
		$fatal(1, "Watchdog expired");
	end

	initial
	begin
		int spin;
		rst = 1'b1;
		mem_read_value = '0;
		rd_q = '0;
		s_addr = '0;
		s_we = 1'b0;
		s_wdata = '0;
		s_rst = 1'b1;
		exp_idx = 0;
		ref_ready = 0;
		seed = 32'h19b7_437c;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = word_t'(i * 20'h3b9) ^ word_t'(i << 7) ^ 20'h5a5a5;
		for (int i = 0; i < 32; i++)
			mem[4000 + i] = word_t'($random(seed));
		build_program();
		steps = run_reference();
		ref_ready = 1;
		// Ten reset edges, then release on the falling edge
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (exp_idx < exp_addr.size())
			@(posedge clk);
		// Final goto refetches its own word every cycle
		spin = 0;
		while (spin < 4)
		begin
			@(posedge clk);
			if (s_addr == addr_t'(end_word))
				spin++;
			else
				spin = 0;
		end
		$display("All checks passed");
		$finish;
	end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD = 4.0
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
	end

	// Free running clock
	always
	begin
		#(PERIOD / 2.0);
		clk = ~clk;
	end

endmodule

/* verilog/lisp_core.sv */
`timescale 1ns/1ps
`include "lisp_consts.svh"

module lisp_core (
	input  logic            clk,
	input  logic            rst,
	output lisp_pkg::addr_t memory_address,
	input  lisp_pkg::word_t mem_read_value,
	output lisp_pkg::word_t mem_write_value,
	output logic            mem_write_enable
);
	import lisp_pkg::*;

	addr_t fetch_addr;
	logic  tos_zero;

	decode_if dec_if ();
	ctrl_if   ctl_if ();

	fetch_unit fetch0 (
		.clk            (clk),
		.rst            (rst),
		.dec            (dec_if.src),
		.ctl            (ctl_if.fetch),
		.mem_read_value (mem_read_value),
		.fetch_addr     (fetch_addr)
	);

	stack_datapath dp0 (
		.clk              (clk),
		.rst              (rst),
		.dec              (dec_if.dst),
		.ctl              (ctl_if.dp),
		.fetch_addr       (fetch_addr),
		.mem_read_value   (mem_read_value),
		.memory_address   (memory_address),
		.mem_write_value  (mem_write_value),
		.mem_write_enable (mem_write_enable),
		.tos_zero         (tos_zero)
	);

	control_fsm fsm0 (
		.clk      (clk),
		.rst      (rst),
		.dec      (dec_if.dst),
		.ctl      (ctl_if.ctrl),
		.tos_zero (tos_zero)
	);

endmodule

/* verilog/control_fsm.sv */
`timescale 1ns/1ps
`include "lisp_consts.svh"

module control_fsm (
	input logic   clk,
	input logic   rst,
	decode_if.dst dec,
	ctrl_if.ctrl  ctl,
	input logic   tos_zero
);
	import lisp_pkg::*;

	state_e state_q;
	state_e state_d;
	// Set when bfalse already moved the IP during decode
	logic   ip_moved_q;

	always_comb
	begin
		state_d = state_q;
		ctl.sp_sel = sp_current;
		ctl.op0_sel = op0_tos;
		ctl.op1_sel = op1_mem;
		ctl.alu_op = dec.opcode;
		ctl.tos_sel = tos_current;
		ctl.ma_sel = ma_ip;
		ctl.mw_sel = mw_tos;
		ctl.we = 1'b0;
		ctl.ip_sel = ip_current;

		case (state_q)
			st_fetch:
			begin
				ctl.ip_sel = ip_next;
				state_d = st_decode;
			end

			st_decode:
			begin
				case (dec.opcode)
					op_push, op_dup:
					begin
						// Spill TOS to SP-1
						ctl.sp_sel = sp_decrement;
						ctl.ma_sel = ma_alu;
						ctl.op0_sel = op0_sp;
						ctl.op1_sel = op1_one;
						ctl.alu_op = op_sub;
						ctl.we = 1'b1;
						if (dec.opcode == op_push)
							ctl.tos_sel = tos_param;
						state_d = st_fetch;
					end

					op_pop:
					begin
						ctl.ma_sel = ma_sp;
						ctl.sp_sel = sp_increment;
						state_d = st_push_mem;
					end

					op_load:
					begin
						ctl.ma_sel = ma_tos;
						state_d = st_push_mem;
					end

					op_store, op_add, op_sub, op_gtr, op_gte, op_eq, op_neq,
					op_and, op_or, op_xor, op_lshift, op_rshift:
					begin
						// Read next-on-stack first
						ctl.ma_sel = ma_sp;
						state_d = st_got_nos;
					end

					op_goto:
					begin
						ctl.ip_sel = ip_branch;
						state_d = st_decode;
					end

					op_bfalse:
					begin
						ctl.ip_sel = tos_zero ? ip_branch : ip_next;
						ctl.sp_sel = sp_increment;
						ctl.ma_sel = ma_sp;
						state_d = st_push_mem;
					end

					default:
					begin
						ctl.ip_sel = ip_next;
						state_d = st_decode;
					end
				endcase
			end

			st_got_nos:
			begin
				ctl.sp_sel = sp_increment;
				if (dec.opcode == op_store)
				begin
					// NOS goes to the address held in TOS
					ctl.ma_sel = ma_tos;
					ctl.we = 1'b1;
					ctl.mw_sel = mw_mem;
					state_d = st_load_tos;
				end
				else
				begin
					ctl.tos_sel = tos_alu;
					ctl.ip_sel = ip_next;
					state_d = st_decode;
				end
			end

			st_load_tos:
			begin
				ctl.ma_sel = ma_sp;
				ctl.sp_sel = sp_increment;
				state_d = st_push_mem;
			end

			st_push_mem:
			begin
				ctl.tos_sel = tos_mem;
				if (!ip_moved_q)
					ctl.ip_sel = ip_next;
				state_d = st_decode;
			end

			default:
				state_d = st_fetch;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q <= st_fetch;
			ip_moved_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			ip_moved_q <= (state_q == st_decode) && (dec.opcode == op_bfalse);
		end
	end

	a_state_legal: assert property (@(posedge clk) disable iff (rst)
		state_q inside {st_fetch, st_decode, st_got_nos, st_load_tos, st_push_mem});

	a_we_states: assert property (@(posedge clk) disable iff (rst)
		ctl.we |-> (state_q inside {st_decode, st_got_nos}));

endmodule

/* verilog/stack_datapath.sv */
`timescale 1ns/1ps
`include "lisp_consts.svh"

module stack_datapath (
	input  logic            clk,
	input  logic            rst,
	decode_if.dst           dec,
	ctrl_if.dp              ctl,
	input  lisp_pkg::addr_t fetch_addr,
	input  lisp_pkg::word_t mem_read_value,
	output lisp_pkg::addr_t memory_address,
	output lisp_pkg::word_t mem_write_value,
	output logic            mem_write_enable,
	output logic            tos_zero
);
	import lisp_pkg::*;

	word_t tos_q;
	word_t tos_d;
	addr_t sp_q;
	addr_t sp_d;
	addr_t op0;
	addr_t op1;
	addr_t alu_res;
	addr_t diff;
	logic  diff_zero;
	logic  diff_neg;

	// Stack pointer next value
	always_comb
	begin
		case (ctl.sp_sel)
			sp_decrement: sp_d = sp_q - addr_t'(1);
			sp_increment: sp_d = sp_q + addr_t'(1);
			default:      sp_d = sp_q;
		endcase
	end

	// ALU operands
	assign op0 = (ctl.op0_sel == op0_sp) ? sp_q : tos_q[15:0];

	always_comb
	begin
		case (ctl.op1_sel)
			op1_param: op1 = dec.param[15:0];
			op1_one:   op1 = addr_t'(1);
			default:   op1 = mem_read_value[15:0];
		endcase
	end

	assign diff = op0 - op1;
	assign diff_zero = (diff == '0);
	assign diff_neg = diff[15];

	always_comb
	begin
		case (ctl.alu_op)
			op_add:    alu_res = op0 + op1;
			op_sub:    alu_res = diff;
			op_gtr:    alu_res = {15'd0, ~diff_neg & ~diff_zero};
			op_gte:    alu_res = {15'd0, ~diff_neg};
			op_eq:     alu_res = {15'd0, diff_zero};
			op_neq:    alu_res = {15'd0, ~diff_zero};
			op_and:    alu_res = op0 & op1;
			op_or:     alu_res = op0 | op1;
			op_xor:    alu_res = op0 ^ op1;
			op_lshift: alu_res = op0 << op1;
			op_rshift: alu_res = op0 >> op1;
			default:   alu_res = '0;
		endcase
	end

	// Top of stack next value, tag bits kept on ALU results
	always_comb
	begin
		case (ctl.tos_sel)
			tos_param: tos_d = dec.param;
			tos_alu:   tos_d = {tos_q[19:16], alu_res};
			tos_mem:   tos_d = mem_read_value;
			default:   tos_d = tos_q;
		endcase
	end

	// Memory address
	always_comb
	begin
		case (ctl.ma_sel)
			ma_sp:   memory_address = sp_q;
			ma_tos:  memory_address = tos_q[15:0];
			ma_alu:  memory_address = alu_res;
			default: memory_address = fetch_addr;
		endcase
	end

	assign mem_write_value = (ctl.mw_sel == mw_mem) ? mem_read_value : tos_q;
	assign mem_write_enable = ctl.we;
	assign tos_zero = (tos_q[15:0] == '0);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			tos_q <= '0;
			sp_q <= addr_t'(`LISP_SP_RESET);
		end
		else
		begin
			tos_q <= tos_d;
			sp_q <= sp_d;
		end
	end

	a_sp_in_range: assert property (@(posedge clk) disable iff (rst)
		sp_q < `LISP_MEM_SIZE);

endmodule

/* verilog/fetch_unit.sv */
`timescale 1ns/1ps
`include "lisp_consts.svh"

module fetch_unit (
	input  logic          clk,
	input  logic          rst,
	decode_if.src         dec,
	ctrl_if.fetch         ctl,
	input  lisp_pkg::word_t mem_read_value,
	output lisp_pkg::addr_t fetch_addr
);
	import lisp_pkg::*;

	ip_t     ip_q;
	ip_t     ip_d;
	word_t   word_q;
	word_t   cur_word;
	logic    in_decode_q;
	opcode_e opcode;
	word_t   param;
	logic    has_param;

	// Fresh word comes straight from memory in decode
	assign cur_word = in_decode_q ? mem_read_value : word_q;

	// Slot alignment with sign-extended parameter from the remaining bits
	always_comb
	begin
		case (ip_q[1:0])
			2'd0:
			begin
				opcode = opcode_e'(cur_word[19:15]);
				param = {{5{cur_word[14]}}, cur_word[14:0]};
			end
			2'd1:
			begin
				opcode = opcode_e'(cur_word[14:10]);
				param = {{10{cur_word[9]}}, cur_word[9:0]};
			end
			2'd2:
			begin
				opcode = opcode_e'(cur_word[9:5]);
				param = {{15{cur_word[4]}}, cur_word[4:0]};
			end
			default:
			begin
				opcode = opcode_e'(cur_word[4:0]);
				param = '0;
			end
		endcase
	end

	assign has_param = (opcode[4:3] == 2'b11);

	assign dec.opcode = opcode;
	assign dec.param = param;
	assign dec.has_param = has_param;

	// Next instruction pointer
	always_comb
	begin
		case (ctl.ip_sel)
			ip_next:
				// Parameterized opcodes use the rest of the word
				ip_d = has_param ? {ip_q[21:2], 2'b00} + 22'd4 : ip_q + 22'd1;
			ip_branch:
				ip_d = {ip_q[21:2], 2'b00} + {param, 2'b00};
			default:
				ip_d = ip_q;
		endcase
	end

	assign fetch_addr = ip_d[`LISP_ADDR_W+1:2];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ip_q <= '1;
			word_q <= '0;
			in_decode_q <= 1'b0;
		end
		else
		begin
			ip_q <= ip_d;
			// An instruction fetch this cycle means decode in the next
			in_decode_q <= (ctl.ma_sel == ma_ip);
			if (in_decode_q)
				word_q <= mem_read_value;
		end
	end

	a_slot3_no_param: assert property (@(posedge clk) disable iff (rst)
		(ip_q[1:0] == 2'd3) |-> (dec.param == '0));

endmodule

/* verilog/core_ifs.sv */
`timescale 1ns/1ps

// Decoded instruction slot
interface decode_if;
	import lisp_pkg::*;

	opcode_e opcode;
	word_t   param;
	logic    has_param;

	modport src (
		output opcode,
		output param,
		output has_param
	);

	modport dst (
		input opcode,
		input param,
		input has_param
	);
endinterface

// Per-cycle select controls from the sequencer
interface ctrl_if;
	import lisp_pkg::*;

	sp_sel_e  sp_sel;
	op0_sel_e op0_sel;
	op1_sel_e op1_sel;
	opcode_e  alu_op;
	tos_sel_e tos_sel;
	ma_sel_e  ma_sel;
	mw_sel_e  mw_sel;
	logic     we;
	ip_sel_e  ip_sel;

	modport ctrl (
		output sp_sel, op0_sel, op1_sel, alu_op, tos_sel,
		output ma_sel, mw_sel, we, ip_sel
	);

	modport dp (
		input sp_sel, op0_sel, op1_sel, alu_op, tos_sel,
		input ma_sel, mw_sel, we
	);

	modport fetch (
		input ip_sel, ma_sel
	);
endinterface

/* verilog/lisp_pkg.sv */
`include "lisp_consts.svh"

package lisp_pkg;

	typedef logic [`LISP_WORD_W-1:0] word_t;
	typedef logic [`LISP_ADDR_W-1:0] addr_t;

	// Word address in the upper bits, slot number in the low two
	typedef logic [`LISP_WORD_W+1:0] ip_t;

	// Opcodes with a parameter have both upper bits set
	typedef enum logic [`LISP_OPCODE_W-1:0] {
		op_nop    = 5'd0,
		op_pop    = 5'd3,
		op_load   = 5'd4,
		op_store  = 5'd5,
		op_add    = 5'd6,
		op_sub    = 5'd7,
		op_gtr    = 5'd9,
		op_gte    = 5'd10,
		op_eq     = 5'd11,
		op_neq    = 5'd12,
		op_dup    = 5'd13,
		op_and    = 5'd16,
		op_or     = 5'd17,
		op_xor    = 5'd18,
		op_lshift = 5'd19,
		op_rshift = 5'd20,
		op_push   = 5'd25,
		op_goto   = 5'd26,
		op_bfalse = 5'd27
	} opcode_e;

	typedef enum logic [3:0] {
		st_fetch    = 4'd0,
		st_decode   = 4'd1,
		st_got_nos  = 4'd2,
		st_load_tos = 4'd3,
		st_push_mem = 4'd4
	} state_e;

	typedef enum logic [1:0] {sp_current, sp_decrement, sp_increment} sp_sel_e;
	typedef enum logic {op0_tos, op0_sp} op0_sel_e;
	typedef enum logic [1:0] {op1_mem, op1_param, op1_one} op1_sel_e;
	typedef enum logic [1:0] {tos_current, tos_param, tos_alu, tos_mem} tos_sel_e;
	typedef enum logic [1:0] {ma_ip, ma_sp, ma_tos, ma_alu} ma_sel_e;
	typedef enum logic {mw_tos, mw_mem} mw_sel_e;
	typedef enum logic [1:0] {ip_current, ip_next, ip_branch} ip_sel_e;

endpackage

/* verilog/lisp_consts.svh */
`ifndef LISP_CONSTS_SVH
`define LISP_CONSTS_SVH

// Data and instruction word width
`define LISP_WORD_W 20

// Memory address and stack pointer width
`define LISP_ADDR_W 16

`define LISP_OPCODE_W 5

// Memory size in words
`define LISP_MEM_SIZE 8192

// Stack starts a few words below the top of memory
`define LISP_SP_RESET (`LISP_MEM_SIZE - 8)

`endif
